// File: hw/audio_fmt_pkg.sv
// Audio sample, coefficient and DAC word widths with their data types
package audio_fmt_pkg;

    // ADC input word from the converter, signed
    parameter int ADC_W = 24;

    // Working sample width inside the filter
    parameter int SAMPLE_W = 16;

    // DAC word as the converter expects it
    parameter int DAC_W = 32;

    // Coefficient width and fraction bits, Q2.14
    parameter int COEF_W    = 16;
    parameter int COEF_FRAC = 14;

    // Raw 24-bit signed sample from the ADC
    typedef logic signed [ADC_W-1:0] adc_word_t;

    // Truncated sample, top 16 bits of the ADC word
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Signed fixed point coefficient
    // 1.0 is 16384, range just under +/-2.0
    typedef logic signed [COEF_W-1:0] coef_t;

    // Packed output word
    // 8 pad bits, 16-bit audio, 8 pad bits
    typedef logic [DAC_W-1:0] dac_word_t;

endpackage

// File: hw/filter_ctrl_pkg.sv
// Sequencer states, filter mode codes, tap count and coefficient tables
package filter_ctrl_pkg;

    // One MAC step per biquad term
    parameter int NUM_TAPS = 5;

    // Mode input codes, code 3 is unused and treated as bypass
    typedef enum logic [1:0] {
        MODE_BYPASS   = 2'd0,
        MODE_BANDPASS = 2'd1,
        MODE_HALF     = 2'd2
    } filt_mode_e;

    // Per-sample walk: wait, five MACs, round, write out
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        MAC   = 2'd1,
        ROUND = 2'd2,
        WRITE = 2'd3
    } seq_state_e;

    // Shared constants in Q2.14
    parameter audio_fmt_pkg::coef_t COEF_ZERO = 16'sd0;
    parameter audio_fmt_pkg::coef_t COEF_ONE  = 16'sd16384;
    parameter audio_fmt_pkg::coef_t COEF_HALF = 16'sd8192;

    // Bandpass set, b = 0.9676 -1.8868 0.9221
    parameter audio_fmt_pkg::coef_t BP_B0 = 16'sd15853;
    parameter audio_fmt_pkg::coef_t BP_B1 = -16'sd30913;
    parameter audio_fmt_pkg::coef_t BP_B2 = 16'sd15108;

    // Feedback terms held as -a1 and -a2
    // a1 = -1.8861, a2 = 0.8922
    parameter audio_fmt_pkg::coef_t BP_NEG_A1 = 16'sd30902;
    parameter audio_fmt_pkg::coef_t BP_NEG_A2 = -16'sd14618;

endpackage

// File: hw/tap_counter.sv
// Tap index counter for one MAC pass with last-tap flag
module tap_counter
    import filter_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       tap_en,
    output logic [2:0] tap_index,
    output logic       last_tap
);

    // Index of the final feedback tap
    localparam logic [2:0] LAST_IDX = 3'(NUM_TAPS - 1);

    // Raised during the final MAC cycle so the FSM leaves MAC on that edge
    assign last_tap = (tap_index == LAST_IDX);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tap_index <= '0;
        end else if (clear) begin
            // New sample restarts at b0
            tap_index <= '0;
        end else if (tap_en) begin
            // Wrap after the last tap
            if (last_tap) begin
                tap_index <= '0;
            end else begin
                tap_index <= tap_index + 3'd1;
            end
        end
    end

endmodule

// File: hw/biquad_sequencer.sv
// Biquad control FSM: sample accept, MAC pass, round, write and overrun flag
module biquad_sequencer
    import filter_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic sample_strobe,
    input  logic last_tap,
    output logic accept,
    output logic tap_en,
    output logic round,
    output logic write,
    output logic overrun
);

    seq_state_e state_q;
    seq_state_e state_d;

    // Strobe only counts while waiting
    assign accept = sample_strobe && (state_q == IDLE);

    // Step strobes, one per state
    assign tap_en = (state_q == MAC);
    assign round  = (state_q == ROUND);
    assign write  = (state_q == WRITE);

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (sample_strobe) begin
                    state_d = MAC;
                end
            end
            MAC: begin
                // Five MAC cycles, exit on the one flagged last
                if (last_tap) begin
                    state_d = ROUND;
                end
            end
            ROUND: begin
                state_d = WRITE;
            end
            WRITE: begin
                // Back to IDLE, next strobe can be taken right away
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Busy strobe gets dropped
    // flag lasts one cycle after the edge that saw it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            overrun <= 1'b0;
        end else begin
            overrun <= sample_strobe && (state_q != IDLE);
        end
    end

endmodule

// File: hw/coef_bank.sv
// Mode latch and per-mode coefficient table indexed by tap
module coef_bank
    import audio_fmt_pkg::*;
    import filter_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       accept,
    input  filt_mode_e mode,
    input  logic [2:0] tap_index,
    output coef_t      coef
);

    // Mode frozen for the sample in flight
    filt_mode_e mode_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode_q <= MODE_BYPASS;
        end else if (accept) begin
            mode_q <= mode;
        end
    end

    // Tap order: b0 b1 b2 -a1 -a2
    always_comb begin
        coef = COEF_ZERO;
        case (mode_q)
            MODE_BANDPASS: begin
                case (tap_index)
                    3'd0:    coef = BP_B0;
                    3'd1:    coef = BP_B1;
                    3'd2:    coef = BP_B2;
                    3'd3:    coef = BP_NEG_A1;
                    3'd4:    coef = BP_NEG_A2;
                    default: coef = COEF_ZERO;
                endcase
            end
            MODE_HALF: begin
                // Only the direct term, 0.5
                if (tap_index == 3'd0) begin
                    coef = COEF_HALF;
                end
            end
            default: begin
                // Bypass and the spare code, unity on x[n]
                if (tap_index == 3'd0) begin
                    coef = COEF_ONE;
                end
            end
        endcase
    end

endmodule

// File: hw/biquad_datapath.sv
// Biquad history, shared multiplier, guarded accumulator, round and saturate
module biquad_datapath
    import audio_fmt_pkg::*;
#(
    parameter int ACC_GUARD = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  sample_t    sample,
    input  coef_t      coef,
    input  logic [2:0] tap_index,
    input  logic       tap_en,
    input  logic       round,
    output sample_t    result
);

    // Full product width, then guard bits against MAC growth
    localparam int PROD_W = SAMPLE_W + COEF_W;
    localparam int ACC_W  = PROD_W + ACC_GUARD;

    // Half an LSB of the output, added before the shift
    localparam logic signed [ACC_W-1:0] RND_HALF = ACC_W'(2 ** (COEF_FRAC - 1));

    // Output range limits at accumulator width
    localparam logic signed [ACC_W-1:0] SAT_MAX = ACC_W'(2 ** (SAMPLE_W - 1) - 1);
    localparam logic signed [ACC_W-1:0] SAT_MIN = -ACC_W'(2 ** (SAMPLE_W - 1));

    // Filter history
    sample_t x1;
    sample_t x2;
    sample_t y1;
    sample_t y2;

    sample_t                    operand;
    logic signed [PROD_W-1:0]   prod;
    logic signed [ACC_W-1:0]    prod_ext;
    logic signed [ACC_W-1:0]    acc;
    logic signed [ACC_W-1:0]    acc_rnd;
    logic signed [ACC_W-1:0]    acc_shr;
    sample_t                    sat_val;

    // Operand follows the tap order
    always_comb begin
        case (tap_index)
            3'd0:    operand = sample;
            3'd1:    operand = x1;
            3'd2:    operand = x2;
            3'd3:    operand = y1;
            3'd4:    operand = y2;
            default: operand = '0;
        endcase
    end

    // Single shared multiplier, signed Q1.15 x Q2.14
    assign prod     = operand * coef;
    assign prod_ext = ACC_W'(prod);

    // Accumulator, loads on b0 and adds the rest
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (tap_en) begin
            if (tap_index == 3'd0) begin
                acc <= prod_ext;
            end else begin
                acc <= acc + prod_ext;
            end
        end
    end

    // Round to nearest, drop the fraction bits
    assign acc_rnd = acc + RND_HALF;
    assign acc_shr = acc_rnd >>> COEF_FRAC;

    // Clip to 16-bit signed
    always_comb begin
        if (acc_shr > SAT_MAX) begin
            sat_val = sample_t'(SAT_MAX);
        end else if (acc_shr < SAT_MIN) begin
            sat_val = sample_t'(SAT_MIN);
        end else begin
            sat_val = acc_shr[SAMPLE_W-1:0];
        end
    end

    // Round step: hold the result and shift both delay lines
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;
            x1     <= '0;
            x2     <= '0;
            y1     <= '0;
            y2     <= '0;
        end else if (round) begin
            result <= sat_val;
            x2     <= x1;
            x1     <= sample;
            y2     <= y1;
            // Feedback uses the clipped value, same as the output
            y1     <= sat_val;
        end
    end

endmodule

// File: hw/sample_format.sv
// ADC word capture and truncation, DAC word packing with valid pulse
module sample_format
    import audio_fmt_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  adc_word_t adc_data,
    input  logic      accept,
    input  logic      write,
    input  sample_t   result,
    output sample_t   sample,
    output dac_word_t dac_data,
    output logic      dac_valid
);

    // Zero bits on each side of the audio field
    localparam int PAD_W = (DAC_W - SAMPLE_W) / 2;

    // Keep the top 16 bits, low 8 bits of the ADC word dropped
    always_ff @(posedge clk) begin
        if (accept) begin
            sample <= adc_data[ADC_W-1 -: SAMPLE_W];
        end
    end

    // Output word held until the next write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dac_data <= '0;
        end else if (write) begin
            dac_data <= {{PAD_W{1'b0}}, result, {PAD_W{1'b0}}};
        end
    end

    // One cycle per new word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dac_valid <= 1'b0;
        end else begin
            dac_valid <= write;
        end
    end

endmodule

// File: hw/audio_biquad_top.sv
// Audio biquad top level: sequencer, tap counter, coefficients, datapath, formatter
module audio_biquad_top
    import audio_fmt_pkg::*;
    import filter_ctrl_pkg::*;
#(
    parameter int ACC_GUARD = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  adc_word_t  adc_data,
    input  logic       sample_strobe,
    input  filt_mode_e mode,
    output dac_word_t  dac_data,
    output logic       dac_valid,
    output logic       overrun
);

    // Control strobes from the FSM
    logic       accept;
    logic       tap_en;
    logic       round;
    logic       write;

    // Tap walk
    logic [2:0] tap_index;
    logic       last_tap;

    // Data between blocks
    coef_t      coef;
    sample_t    sample;
    sample_t    result;

    biquad_sequencer u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_strobe (sample_strobe),
        .last_tap      (last_tap),
        .accept        (accept),
        .tap_en        (tap_en),
        .round         (round),
        .write         (write),
        .overrun       (overrun)
    );

    tap_counter u_taps (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (accept),
        .tap_en    (tap_en),
        .tap_index (tap_index),
        .last_tap  (last_tap)
    );

    coef_bank u_coef (
        .clk       (clk),
        .rst_n     (rst_n),
        .accept    (accept),
        .mode      (mode),
        .tap_index (tap_index),
        .coef      (coef)
    );

    biquad_datapath #(
        .ACC_GUARD (ACC_GUARD)
    ) u_dp (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample    (sample),
        .coef      (coef),
        .tap_index (tap_index),
        .tap_en    (tap_en),
        .round     (round),
        .result    (result)
    );

    sample_format u_fmt (
        .clk       (clk),
        .rst_n     (rst_n),
        .adc_data  (adc_data),
        .accept    (accept),
        .write     (write),
        .result    (result),
        .sample    (sample),
        .dac_data  (dac_data),
        .dac_valid (dac_valid)
    );

endmodule

// File: tests/audio_biquad_asserts.sv
// Port-level concurrent assertions for the audio biquad top, with its bind
module audio_biquad_asserts
    import audio_fmt_pkg::*;
    import filter_ctrl_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input adc_word_t  adc_data,
    input logic       sample_strobe,
    input filt_mode_e mode,
    input dac_word_t  dac_data,
    input logic       dac_valid,
    input logic       overrun
);

    // Busy window E1 to E7 after an accepted strobe
    logic [2:0]         busy_cnt;
    logic               accepted;
    logic               dropped;
    // Set once a strobe was taken since reset
    logic               seen_accept;
    // Any nonzero input since reset
    logic               nonzero_in;
    // Sample and mode as seen at the accepting edge
    sample_t            exp_sample;
    filt_mode_e         exp_mode;
    logic signed [16:0] half_sum;
    sample_t            exp_half;
    int                 fail_count = 0;

    assign accepted = sample_strobe && (busy_cnt == 3'd0);
    assign dropped  = sample_strobe && (busy_cnt != 3'd0);

    // b0 = 0.5 with round half up gives (x + 1) >>> 1
    assign half_sum = exp_sample + 17'sd1;
    assign exp_half = sample_t'(half_sum >>> 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_cnt    <= 3'd0;
            seen_accept <= 1'b0;
            nonzero_in  <= 1'b0;
            exp_sample  <= '0;
            exp_mode    <= MODE_BYPASS;
        end else if (accepted) begin
            busy_cnt    <= 3'd7;
            seen_accept <= 1'b1;
            exp_sample  <= adc_data[ADC_W-1 -: SAMPLE_W];
            exp_mode    <= mode;
            if (adc_data[ADC_W-1 -: SAMPLE_W] != '0) begin
                nonzero_in <= 1'b1;
            end
        end else if (busy_cnt != 3'd0) begin
            busy_cnt <= busy_cnt - 3'd1;
        end
    end

    task automatic flag_failure(input string what);
        $error("%s", what);
        fail_count++;
    endtask

    // Quiet outputs until the first accepted sample
    a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_accept |-> (!dac_valid && !overrun && dac_data == '0))
        else flag_failure("outputs active before the first accepted strobe");

    // Word registered at E7, seen at the following edge
    a_valid_after: assert property (@(posedge clk) disable iff (!rst_n)
        accepted |-> ##8 dac_valid)
        else flag_failure("no dac_valid 7 cycles after an accepted strobe");
    a_valid_cause: assert property (@(posedge clk) disable iff (!rst_n)
        dac_valid |-> $past(accepted, 8))
        else flag_failure("dac_valid without a matching accepted strobe");
    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        dac_valid |=> !dac_valid)
        else flag_failure("dac_valid longer than one cycle");
    a_pads: assert property (@(posedge clk) disable iff (!rst_n)
        dac_valid |-> (dac_data[31:24] == 8'h00 && dac_data[7:0] == 8'h00))
        else flag_failure("nonzero pad bits in the DAC word");

    // Data checks against the latched mode
    a_bypass: assert property (@(posedge clk) disable iff (!rst_n)
        (dac_valid && exp_mode == MODE_BYPASS) |-> dac_data[23:8] == exp_sample)
        else flag_failure("bypass output differs from the sampled input");
    a_half: assert property (@(posedge clk) disable iff (!rst_n)
        (dac_valid && exp_mode == MODE_HALF) |-> dac_data[23:8] == exp_half)
        else flag_failure("half gain output differs from the rounded half");
    a_bp_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (dac_valid && exp_mode == MODE_BANDPASS && !nonzero_in) |-> dac_data == '0)
        else flag_failure("bandpass output nonzero with zero input");

    // Dropped strobe flags overrun on the next cycle only
    a_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        dropped |=> overrun)
        else flag_failure("dropped strobe without overrun");
    a_overrun_cause: assert property (@(posedge clk) disable iff (!rst_n)
        overrun |-> $past(dropped))
        else flag_failure("overrun without a dropped strobe");

endmodule

bind audio_biquad_top audio_biquad_asserts u_asserts (
    .clk           (clk),
    .rst_n         (rst_n),
    .adc_data      (adc_data),
    .sample_strobe (sample_strobe),
    .mode          (mode),
    .dac_data      (dac_data),
    .dac_valid     (dac_valid),
    .overrun       (overrun)
);

// File: tests/audio_biquad_tb.sv
// Testbench for the audio biquad: clock, reset, stimulus phases, pulse counts, timeout
module audio_biquad_tb
    import audio_fmt_pkg::*;
    import filter_ctrl_pkg::*;
();

    // Reset, 80 strobes at up to 24 cycles each, some margin
    localparam int TIMEOUT_CYCLES = 4 + 80 * 24 + 100;

    logic       clk = 1'b0;
    logic       rst_n;
    adc_word_t  adc_data;
    logic       sample_strobe;
    filt_mode_e mode;
    dac_word_t  dac_data;
    logic       dac_valid;
    logic       overrun;

    integer seed = 74887;
    // Edges since the last accepted strobe
    int     since_accept = 100;
    int     exp_accepted = 0;
    int     exp_dropped = 0;
    int     valid_count = 0;
    int     overrun_count = 0;
    int     count_errors = 0;
    int     cycle_count = 0;

    audio_biquad_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .adc_data      (adc_data),
        .sample_strobe (sample_strobe),
        .mode          (mode),
        .dac_data      (dac_data),
        .dac_valid     (dac_valid),
        .overrun       (overrun)
    );

    always #20 clk = ~clk;

    // Pulse counters
    always @(posedge clk) begin
        if (rst_n && dac_valid) begin
            valid_count++;
        end
        if (rst_n && overrun) begin
            overrun_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Ends 2 time units after the n-th rising edge
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        wait_cycles(4);
        rst_n = 1'b1;
        since_accept = 100;
    endtask

    // One-cycle strobe, next strobe follows after spacing edges
    task automatic send_sample(input adc_word_t value, input filt_mode_e sel, input int spacing);
        // Busy for 7 edges after an accept, taken again from the 8th
        if (since_accept >= 8) begin
            exp_accepted++;
            since_accept = 0;
        end else begin
            exp_dropped++;
        end
        since_accept += spacing;
        adc_data      = value;
        mode          = sel;
        sample_strobe = 1'b1;
        wait_cycles(1);
        sample_strobe = 1'b0;
        wait_cycles(spacing - 1);
    endtask

    function automatic int pick_spacing();
        pick_spacing = 8 + int'($unsigned($random(seed)) % 16);
    endfunction

    task automatic compare_count(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("MISMATCH %s: expected 0x%0h, got 0x%0h", name, expected, actual);
            count_errors++;
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        adc_data      = '0;
        sample_strobe = 1'b0;
        mode          = MODE_BYPASS;
        apply_reset();
        // Idle window for the quiet-output check
        wait_cycles(5);

        for (int i = 0; i < 20; i++) begin
            send_sample(adc_word_t'($random(seed)), MODE_BYPASS, pick_spacing());
        end
        for (int i = 0; i < 20; i++) begin
            send_sample(adc_word_t'($random(seed)), MODE_HALF, pick_spacing());
        end

        // Fresh history, then zero input through the bandpass
        wait_cycles(12);
        apply_reset();
        for (int i = 0; i < 20; i++) begin
            send_sample('0, MODE_BANDPASS, pick_spacing());
        end

        // Every second strobe lands 3 cycles in, with another mode
        // Bandpass feedback taps would alter the bypass sample in flight
        for (int i = 0; i < 20; i++) begin
            if (i % 2 == 0) begin
                send_sample(adc_word_t'($random(seed)), MODE_BYPASS, 3);
            end else begin
                send_sample(adc_word_t'($random(seed)), MODE_BANDPASS, pick_spacing());
            end
        end
        wait_cycles(12);

        compare_count("dac_valid", exp_accepted, valid_count);
        compare_count("overrun", exp_dropped, overrun_count);
        $display("Errors: %0d count mismatches, %0d assertion failures",
                 count_errors, UUT.u_asserts.fail_count);
        if (count_errors + UUT.u_asserts.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: audio_biquad.f
hw/audio_fmt_pkg.sv
hw/filter_ctrl_pkg.sv
hw/tap_counter.sv
hw/biquad_sequencer.sv
hw/coef_bank.sv
hw/biquad_datapath.sv
hw/sample_format.sv
hw/audio_biquad_top.sv
tests/audio_biquad_asserts.sv
tests/audio_biquad_tb.sv
